/* sim.f */
cache_pkg.sv
cache_set_store.sv
cache_way_select.sv
cache_mesi_ctrl.sv
cache_stats.sv
cache_l2_top.sv
cache_l2_assert.sv
cache_l2_tb.sv

/* Makefile */
TOP = cache_l2_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sim.f *.sv
	verilator --binary --assert -f sim.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* cache_l2_tb.sv */
`timescale 1ns/1ps

module cache_l2_tb;

	localparam int INDEX_W = 14;
	localparam int COUNT_W = 16;
	localparam int TAG_W = cache_pkg::ADDR_WIDTH - INDEX_W - cache_pkg::OFFSET_WIDTH;
	localparam int CLK_PERIOD = 20;
	localparam int NUM_CMDS = 2000;
	// three cycles per command, rest is margin
	localparam int TIMEOUT = NUM_CMDS * 5 * CLK_PERIOD;

	logic clk = 1'b0;
	logic rst;
	logic cmd_valid;
	cache_pkg::cmd_e cmd_op;
	logic [cache_pkg::ADDR_WIDTH-1:0] cmd_addr;
	logic busy;
	logic resp_valid;
	logic resp_hit;
	cache_pkg::snoop_e resp_snoop;
	logic bus_valid;
	cache_pkg::bus_op_e bus_op;
	logic [cache_pkg::ADDR_WIDTH-1:0] bus_addr;
	logic evict_valid;
	logic [cache_pkg::ADDR_WIDTH-1:0] evict_addr;
	logic [COUNT_W-1:0] read_count;
	logic [COUNT_W-1:0] write_count;
	logic [COUNT_W-1:0] hit_count;
	logic [COUNT_W-1:0] miss_count;

	integer seed = 68441;

	// address pool, sets must lie in the range cleared during reset
	logic [INDEX_W-1:0] set_pool [2];
	logic [TAG_W-1:0] tag_pool [12];
	cache_pkg::cmd_e op_list [6];

	// reference copy of the two pool sets
	logic [TAG_W-1:0] m_tag [2][cache_pkg::WAYS];
	cache_pkg::mesi_e m_state [2][cache_pkg::WAYS];
	logic [2:0] m_lru [2][cache_pkg::WAYS];
	logic [COUNT_W-1:0] n_read;
	logic [COUNT_W-1:0] n_write;
	logic [COUNT_W-1:0] n_hit;
	logic [COUNT_W-1:0] n_miss;

	cache_l2_top #(.INDEX_WIDTH(INDEX_W), .COUNT_WIDTH(COUNT_W)) i_dut (
		.clk, .rst, .cmd_valid, .cmd_op, .cmd_addr, .busy,
		.resp_valid, .resp_hit, .resp_snoop, .bus_valid, .bus_op, .bus_addr,
		.evict_valid, .evict_addr, .read_count, .write_count, .hit_count, .miss_count
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("FAILED at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
			$display("Verification failed");
			$fatal(1, "wrong value on %s", name);
		end
	endtask

	task automatic check_counts();
		check_value("read_count", 32'(n_read), 32'(read_count));
		check_value("write_count", 32'(n_write), 32'(write_count));
		check_value("hit_count", 32'(n_hit), 32'(hit_count));
		check_value("miss_count", 32'(n_miss), 32'(miss_count));
	endtask

	////////////////////////////////////////////////////////////
	// one command: predict, drive, check at t+2
	////////////////////////////////////////////////////////////

	task automatic run_cmd(input cache_pkg::cmd_e op, input int s, input int t);
		logic [31:0] rnd;
		logic [31:0] addr;
		logic hit;
		logic empty;
		logic is_req;
		int hw;
		int ew;
		int lw;
		int vw;
		int tw;
		cache_pkg::mesi_e old;
		cache_pkg::snoop_e ext;
		cache_pkg::snoop_e exp_snoop;
		logic exp_bus;
		cache_pkg::bus_op_e exp_op;
		logic exp_evict;
		logic [31:0] exp_evict_addr;
		logic [2:0] ref_lru;

		rnd = $random(seed);
		addr = {tag_pool[t], set_pool[s], rnd[5:0]};
		hit = 1'b0;
		empty = 1'b0;
		hw = 0;
		ew = 0;
		lw = 0;
		// first live tag, first free way, the oldest way
		for (int w = 0; w < cache_pkg::WAYS; w++)
		begin
			if (!hit && m_state[s][w] != cache_pkg::MESI_I && m_tag[s][w] == tag_pool[t])
			begin
				hit = 1'b1;
				hw = w;
			end
			if (!empty && m_state[s][w] == cache_pkg::MESI_I)
			begin
				empty = 1'b1;
				ew = w;
			end
			if (m_lru[s][w] == 3'd0)
				lw = w;
		end
		vw = empty ? ew : lw;
		tw = hit ? hw : vw;
		old = m_state[s][hw];
		is_req = (op == cache_pkg::CMD_READ || op == cache_pkg::CMD_WRITE ||
			op == cache_pkg::CMD_IFETCH);
		case (addr[1:0])
			2'b00: ext = cache_pkg::SNOOP_HIT;
			2'b10: ext = cache_pkg::SNOOP_HITM;
			default: ext = cache_pkg::SNOOP_MISS;
		endcase
		exp_snoop = cache_pkg::SNOOP_MISS;
		if (!is_req && hit)
			exp_snoop = (old == cache_pkg::MESI_M) ? cache_pkg::SNOOP_HITM : cache_pkg::SNOOP_HIT;
		exp_bus = 1'b0;
		exp_op = cache_pkg::BUS_READ;
		exp_evict = is_req && !hit && m_state[s][vw] == cache_pkg::MESI_M;
		exp_evict_addr = {m_tag[s][vw], set_pool[s], 6'b0};

		// protocol rules on the model
		case (op)
			cache_pkg::CMD_READ, cache_pkg::CMD_IFETCH:
			begin
				if (!hit)
				begin
					exp_bus = 1'b1;
					m_state[s][vw] = (ext == cache_pkg::SNOOP_MISS) ?
						cache_pkg::MESI_E : cache_pkg::MESI_S;
				end
			end
			cache_pkg::CMD_WRITE:
			begin
				exp_bus = !hit || old == cache_pkg::MESI_S;
				exp_op = hit ? cache_pkg::BUS_INVALIDATE : cache_pkg::BUS_RWIM;
				m_state[s][tw] = cache_pkg::MESI_M;
			end
			cache_pkg::CMD_SNOOP_INV:
				if (hit && old == cache_pkg::MESI_S)
					m_state[s][hw] = cache_pkg::MESI_I;
			cache_pkg::CMD_SNOOP_RD:
				if (hit && (old == cache_pkg::MESI_M || old == cache_pkg::MESI_E))
					m_state[s][hw] = cache_pkg::MESI_S;
			default:
				if (hit)
					m_state[s][hw] = cache_pkg::MESI_I;
		endcase
		if (is_req)
		begin
			// touched way becomes newest
			ref_lru = m_lru[s][tw];
			for (int w = 0; w < cache_pkg::WAYS; w++)
			begin
				if (w == tw)
					m_lru[s][w] = 3'd7;
				else if (m_lru[s][w] > ref_lru)
					m_lru[s][w] = m_lru[s][w] - 3'd1;
			end
			if (!hit)
				m_tag[s][vw] = tag_pool[t];
			if (op == cache_pkg::CMD_WRITE)
				n_write = n_write + 1'b1;
			else
				n_read = n_read + 1'b1;
			if (hit)
				n_hit = n_hit + 1'b1;
			else
				n_miss = n_miss + 1'b1;
		end

		while (busy)
			@(negedge clk);
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_addr = addr;
		@(negedge clk);
		// junk while busy must be ignored
		cmd_addr = $random(seed);
		check_value("busy", 32'(1'b1), 32'(busy));
		check_value("resp_valid", 32'(1'b0), 32'(resp_valid));
		@(negedge clk);
		check_value("resp_valid", 32'(1'b1), 32'(resp_valid));
		check_value("resp_hit", 32'(hit), 32'(resp_hit));
		check_value("resp_snoop", 32'(exp_snoop), 32'(resp_snoop));
		check_value("bus_valid", 32'(exp_bus), 32'(bus_valid));
		if (exp_bus)
		begin
			check_value("bus_op", 32'(exp_op), 32'(bus_op));
			check_value("bus_addr", {addr[31:6], 6'b0}, bus_addr);
		end
		check_value("evict_valid", 32'(exp_evict), 32'(evict_valid));
		if (exp_evict)
			check_value("evict_addr", exp_evict_addr, evict_addr);
		@(negedge clk);
		check_value("busy", 32'(1'b0), 32'(busy));
		check_value("resp_valid", 32'(1'b0), 32'(resp_valid));
		check_counts();
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = cache_pkg::CMD_READ;
		cmd_addr = '0;
		set_pool[0] = 14'd3;
		set_pool[1] = 14'd10;
		for (int k = 0; k < 12; k++)
			tag_pool[k] = TAG_W'(k * 293 + 17);
		op_list[0] = cache_pkg::CMD_READ;
		op_list[1] = cache_pkg::CMD_WRITE;
		op_list[2] = cache_pkg::CMD_IFETCH;
		op_list[3] = cache_pkg::CMD_SNOOP_INV;
		op_list[4] = cache_pkg::CMD_SNOOP_RD;
		op_list[5] = cache_pkg::CMD_SNOOP_RWIM;
		for (int s = 0; s < 2; s++)
		begin
			for (int w = 0; w < cache_pkg::WAYS; w++)
			begin
				m_tag[s][w] = '0;
				m_state[s][w] = cache_pkg::MESI_I;
				m_lru[s][w] = 3'(w);
			end
		end
		n_read = '0;
		n_write = '0;
		n_hit = '0;
		n_miss = '0;

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_value("busy", 32'(1'b0), 32'(busy));
		check_value("resp_valid", 32'(1'b0), 32'(resp_valid));
		check_value("bus_valid", 32'(1'b0), 32'(bus_valid));
		check_value("evict_valid", 32'(1'b0), 32'(evict_valid));
		check_counts();

		// nine tags in one set, the ninth evicts a modified way
		for (int k = 0; k < 9; k++)
			run_cmd(cache_pkg::CMD_WRITE, 0, k);

		for (int n = 0; n < NUM_CMDS; n++)
			run_cmd(op_list[$unsigned($random(seed)) % 6], $unsigned($random(seed)) % 2,
				$unsigned($random(seed)) % 12);
		cmd_valid = 1'b0;
		@(negedge clk);
		$display("Verification passed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(TIMEOUT);
		$display("timeout, the command sequence did not finish in %0d ns", TIMEOUT);
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* cache_l2_assert.sv */
`timescale 1ns/1ps

module cache_l2_assert (
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input logic busy,
	input logic rd_en,
	input logic resp_valid,
	input logic bus_valid,
	input logic evict_valid
);

	logic take;

	// command accepted this cycle
	assign take = cmd_valid && !busy;

	// response exactly two cycles after a take
	take_to_resp: assert property (@(posedge clk) disable iff (rst)
		$past(take, 2) |-> resp_valid)
		else $error("response missing two cycles after an accepted command");
	resp_from_take: assert property (@(posedge clk) disable iff (rst)
		resp_valid |-> $past(take, 2))
		else $error("response without an accepted command two cycles before");

	// bus pulse rides on the response of an accepted command
	bus_in_resp: assert property (@(posedge clk) disable iff (rst)
		bus_valid |-> resp_valid && $past(take, 2))
		else $error("bus pulse outside a response cycle");
	// write-back only with the miss that reads or claims the line
	evict_in_resp: assert property (@(posedge clk) disable iff (rst)
		evict_valid |-> resp_valid && bus_valid)
		else $error("write-back pulse without a response and a bus request");

	// a command offered while busy starts no lookup
	no_take_busy: assert property (@(posedge clk) disable iff (rst)
		busy && cmd_valid |=> !rd_en)
		else $error("command taken while busy");

endmodule

bind cache_mesi_ctrl cache_l2_assert i_assert (
	.clk(clk),
	.rst(rst),
	.cmd_valid(cmd_valid),
	.busy(busy),
	.rd_en(rd_en),
	.resp_valid(resp_valid),
	.bus_valid(bus_valid),
	.evict_valid(evict_valid)
);

/* cache_l2_top.sv */
`timescale 1ns/1ps

module cache_l2_top #(
	parameter int INDEX_WIDTH = 14,
	parameter int COUNT_WIDTH = 16,
	localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
) (
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input cache_pkg::cmd_e cmd_op,
	input logic [cache_pkg::ADDR_WIDTH-1:0] cmd_addr,
	output logic busy,
	output logic resp_valid,
	output logic resp_hit,
	output cache_pkg::snoop_e resp_snoop,
	output logic bus_valid,
	output cache_pkg::bus_op_e bus_op,
	output logic [cache_pkg::ADDR_WIDTH-1:0] bus_addr,
	output logic evict_valid,
	output logic [cache_pkg::ADDR_WIDTH-1:0] evict_addr,
	output logic [COUNT_WIDTH-1:0] read_count,
	output logic [COUNT_WIDTH-1:0] write_count,
	output logic [COUNT_WIDTH-1:0] hit_count,
	output logic [COUNT_WIDTH-1:0] miss_count
);

	////////////////////////////////////////////////////////////
	// set read and write paths
	////////////////////////////////////////////////////////////

	logic rd_en;
	logic [INDEX_WIDTH-1:0] rd_index;
	logic [cache_pkg::WAYS-1:0][TAG_WIDTH-1:0] rd_tags;
	cache_pkg::mesi_e [cache_pkg::WAYS-1:0] rd_states;
	logic [cache_pkg::WAYS-1:0][cache_pkg::LRU_WIDTH-1:0] rd_lru;
	logic wr_en;
	logic [INDEX_WIDTH-1:0] wr_index;
	logic [cache_pkg::WAYS-1:0][TAG_WIDTH-1:0] wr_tags;
	cache_pkg::mesi_e [cache_pkg::WAYS-1:0] wr_states;
	logic [cache_pkg::WAYS-1:0][cache_pkg::LRU_WIDTH-1:0] wr_lru;

	// way search results
	logic [TAG_WIDTH-1:0] tag;
	logic [cache_pkg::WAY_WIDTH-1:0] touch_way;
	logic match;
	logic [cache_pkg::WAY_WIDTH-1:0] match_way;
	logic empty;
	logic [cache_pkg::WAY_WIDTH-1:0] empty_way;
	logic [cache_pkg::WAY_WIDTH-1:0] victim_way;
	logic [cache_pkg::WAYS-1:0][cache_pkg::LRU_WIDTH-1:0] new_lru;

	// request strobes to the counters
	logic req_done;
	logic req_write;
	logic req_hit;

	cache_set_store #(.INDEX_WIDTH(INDEX_WIDTH)) i_store (
		.clk, .rst, .rd_en, .rd_index, .rd_tags, .rd_states, .rd_lru,
		.wr_en, .wr_index, .wr_tags, .wr_states, .wr_lru
	);

	cache_way_select #(.INDEX_WIDTH(INDEX_WIDTH)) i_way_select (
		.rd_tags, .rd_states, .rd_lru, .tag, .touch_way,
		.match, .match_way, .empty, .empty_way, .victim_way, .new_lru
	);

	cache_mesi_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) i_ctrl (
		.clk, .rst, .cmd_valid, .cmd_op, .cmd_addr, .busy,
		.rd_en, .rd_index, .rd_tags, .rd_states, .rd_lru,
		.match, .match_way, .victim_way, .new_lru, .tag, .touch_way,
		.wr_en, .wr_index, .wr_tags, .wr_states, .wr_lru,
		.resp_valid, .resp_hit, .resp_snoop, .bus_valid, .bus_op, .bus_addr,
		.evict_valid, .evict_addr, .req_done, .req_write, .req_hit
	);

	cache_stats #(.COUNT_WIDTH(COUNT_WIDTH)) i_stats (
		.clk, .rst, .req_done, .req_write, .req_hit,
		.read_count, .write_count, .hit_count, .miss_count
	);

endmodule

/* cache_stats.sv */
`timescale 1ns/1ps

module cache_stats #(
	parameter int COUNT_WIDTH = 16
) (
	input logic clk,
	input logic rst,
	input logic req_done,
	input logic req_write,
	input logic req_hit,
	output logic [COUNT_WIDTH-1:0] read_count,
	output logic [COUNT_WIDTH-1:0] write_count,
	output logic [COUNT_WIDTH-1:0] hit_count,
	output logic [COUNT_WIDTH-1:0] miss_count
);

	// free running, wraps at the top
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			read_count <= '0;
			write_count <= '0;
			hit_count <= '0;
			miss_count <= '0;
		end
		else if (req_done)
		begin
			// data and instruction reads both count as reads
			if (req_write)
				write_count <= write_count + 1'b1;
			else
				read_count <= read_count + 1'b1;
			if (req_hit)
				hit_count <= hit_count + 1'b1;
			else
				miss_count <= miss_count + 1'b1;
		end
	end

endmodule

/* cache_mesi_ctrl.sv */
`timescale 1ns/1ps

module cache_mesi_ctrl #(
	parameter int INDEX_WIDTH = 14,
	localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
) (
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input cache_pkg::cmd_e cmd_op,
	input logic [cache_pkg::ADDR_WIDTH-1:0] cmd_addr,
	output logic busy,
	output logic rd_en,
	output logic [INDEX_WIDTH-1:0] rd_index,
	input logic [cache_pkg::WAYS-1:0][TAG_WIDTH-1:0] rd_tags,
	input cache_pkg::mesi_e [cache_pkg::WAYS-1:0] rd_states,
	input logic [cache_pkg::WAYS-1:0][cache_pkg::LRU_WIDTH-1:0] rd_lru,
	input logic match,
	input logic [cache_pkg::WAY_WIDTH-1:0] match_way,
	input logic [cache_pkg::WAY_WIDTH-1:0] victim_way,
	input logic [cache_pkg::WAYS-1:0][cache_pkg::LRU_WIDTH-1:0] new_lru,
	output logic [TAG_WIDTH-1:0] tag,
	output logic [cache_pkg::WAY_WIDTH-1:0] touch_way,
	output logic wr_en,
	output logic [INDEX_WIDTH-1:0] wr_index,
	output logic [cache_pkg::WAYS-1:0][TAG_WIDTH-1:0] wr_tags,
	output cache_pkg::mesi_e [cache_pkg::WAYS-1:0] wr_states,
	output logic [cache_pkg::WAYS-1:0][cache_pkg::LRU_WIDTH-1:0] wr_lru,
	output logic resp_valid,
	output logic resp_hit,
	output cache_pkg::snoop_e resp_snoop,
	output logic bus_valid,
	output cache_pkg::bus_op_e bus_op,
	output logic [cache_pkg::ADDR_WIDTH-1:0] bus_addr,
	output logic evict_valid,
	output logic [cache_pkg::ADDR_WIDTH-1:0] evict_addr,
	output logic req_done,
	output logic req_write,
	output logic req_hit
);

	typedef enum logic [1:0] {ST_IDLE, ST_LOOKUP, ST_UPDATE} state_e;

	state_e state;
	cache_pkg::cmd_e op_q;
	logic [cache_pkg::ADDR_WIDTH-1:0] addr_q;
	logic in_update;
	logic is_req;
	logic is_snoop;
	logic alloc;
	logic bus_req;
	cache_pkg::snoop_e ext_snoop;
	cache_pkg::mesi_e hit_state;
	cache_pkg::mesi_e victim_state;

	////////////////////////////////////////////////////////////
	// command sequencing: idle, read set, decide and write
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE: if (cmd_valid) state <= ST_LOOKUP;
				ST_LOOKUP: state <= ST_UPDATE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// command payload, held until the set is written
	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && cmd_valid)
		begin
			op_q <= cmd_op;
			addr_q <= cmd_addr;
		end
	end

	assign busy = (state != ST_IDLE);
	assign in_update = (state == ST_UPDATE);

	// address split of the held command
	assign tag = addr_q[cache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
	assign rd_index = addr_q[cache_pkg::OFFSET_WIDTH +: INDEX_WIDTH];
	assign wr_index = rd_index;
	assign rd_en = (state == ST_LOOKUP);
	assign wr_en = in_update;

	// other caches' answer rides on the low address bits
	always_comb
	begin
		case (addr_q[1:0])
			2'b00: ext_snoop = cache_pkg::SNOOP_HIT;
			2'b10: ext_snoop = cache_pkg::SNOOP_HITM;
			default: ext_snoop = cache_pkg::SNOOP_MISS;
		endcase
	end

	assign is_req = op_q inside {cache_pkg::CMD_READ, cache_pkg::CMD_WRITE, cache_pkg::CMD_IFETCH};
	assign is_snoop = op_q inside {cache_pkg::CMD_SNOOP_INV, cache_pkg::CMD_SNOOP_RD,
		cache_pkg::CMD_SNOOP_RWIM};
	assign alloc = is_req && !match;
	assign hit_state = rd_states[match_way];
	assign victim_state = rd_states[victim_way];
	assign touch_way = match ? match_way : victim_way;

	////////////////////////////////////////////////////////////
	// mesi next state and bus request
	////////////////////////////////////////////////////////////

	always_comb
	begin
		wr_tags = rd_tags;
		wr_states = rd_states;
		// snoops leave the lru order alone
		wr_lru = is_req ? new_lru : rd_lru;
		bus_req = 1'b0;
		bus_op = cache_pkg::BUS_READ;
		if (alloc)
			wr_tags[victim_way] = tag;
		case (op_q)
			cache_pkg::CMD_READ, cache_pkg::CMD_IFETCH:
			begin
				// read hit keeps its state
				if (!match)
				begin
					bus_req = 1'b1;
					wr_states[victim_way] = (ext_snoop == cache_pkg::SNOOP_MISS) ?
						cache_pkg::MESI_E : cache_pkg::MESI_S;
				end
			end
			cache_pkg::CMD_WRITE:
			begin
				if (match)
				begin
					wr_states[match_way] = cache_pkg::MESI_M;
					// shared copies elsewhere must drop
					if (hit_state == cache_pkg::MESI_S)
					begin
						bus_req = 1'b1;
						bus_op = cache_pkg::BUS_INVALIDATE;
					end
				end
				else
				begin
					bus_req = 1'b1;
					bus_op = cache_pkg::BUS_RWIM;
					wr_states[victim_way] = cache_pkg::MESI_M;
				end
			end
			cache_pkg::CMD_SNOOP_INV:
			begin
				if (match && hit_state == cache_pkg::MESI_S)
					wr_states[match_way] = cache_pkg::MESI_I;
			end
			cache_pkg::CMD_SNOOP_RD:
			begin
				if (match && hit_state inside {cache_pkg::MESI_M, cache_pkg::MESI_E})
					wr_states[match_way] = cache_pkg::MESI_S;
			end
			cache_pkg::CMD_SNOOP_RWIM:
			begin
				if (match)
					wr_states[match_way] = cache_pkg::MESI_I;
			end
			// stall and unused codes leave the set as read
			default: ;
		endcase
	end

	// our answer to a snoop
	always_comb
	begin
		if (!is_snoop || !match)
			resp_snoop = cache_pkg::SNOOP_MISS;
		else if (hit_state == cache_pkg::MESI_M)
			resp_snoop = cache_pkg::SNOOP_HITM;
		else
			resp_snoop = cache_pkg::SNOOP_HIT;
	end

	////////////////////////////////////////////////////////////
	// pulses, all in the update cycle
	////////////////////////////////////////////////////////////

	assign resp_valid = in_update;
	assign resp_hit = match;
	assign bus_valid = in_update && bus_req;
	// line aligned
	assign bus_addr = {addr_q[cache_pkg::ADDR_WIDTH-1:cache_pkg::OFFSET_WIDTH],
		{cache_pkg::OFFSET_WIDTH{1'b0}}};
	// modified victim needs a write-back
	assign evict_valid = in_update && alloc && victim_state == cache_pkg::MESI_M;
	assign evict_addr = {rd_tags[victim_way], rd_index, {cache_pkg::OFFSET_WIDTH{1'b0}}};

	// statistics see requests only
	assign req_done = in_update && is_req;
	assign req_write = (op_q == cache_pkg::CMD_WRITE);
	assign req_hit = match;

endmodule

/* cache_way_select.sv */
`timescale 1ns/1ps

module cache_way_select #(
	parameter int INDEX_WIDTH = 14,
	localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
) (
	input logic [cache_pkg::WAYS-1:0][TAG_WIDTH-1:0] rd_tags,
	input cache_pkg::mesi_e [cache_pkg::WAYS-1:0] rd_states,
	input logic [cache_pkg::WAYS-1:0][cache_pkg::LRU_WIDTH-1:0] rd_lru,
	input logic [TAG_WIDTH-1:0] tag,
	input logic [cache_pkg::WAY_WIDTH-1:0] touch_way,
	output logic match,
	output logic [cache_pkg::WAY_WIDTH-1:0] match_way,
	output logic empty,
	output logic [cache_pkg::WAY_WIDTH-1:0] empty_way,
	output logic [cache_pkg::WAY_WIDTH-1:0] victim_way,
	output logic [cache_pkg::WAYS-1:0][cache_pkg::LRU_WIDTH-1:0] new_lru
);

	logic [cache_pkg::WAY_WIDTH-1:0] lru_way;
	logic [cache_pkg::LRU_WIDTH-1:0] touched_lru;

	////////////////////////////////////////////////////////////
	// searches
	////////////////////////////////////////////////////////////

	// walk down so the lowest way wins each search
	always_comb
	begin
		match = 1'b0;
		match_way = '0;
		empty = 1'b0;
		empty_way = '0;
		lru_way = '0;
		for (int w = cache_pkg::WAYS - 1; w >= 0; w--)
		begin
			// tag hit only counts on a live line
			if (rd_tags[w] == tag && rd_states[w] != cache_pkg::MESI_I)
			begin
				match = 1'b1;
				match_way = w[cache_pkg::WAY_WIDTH-1:0];
			end
			if (rd_states[w] == cache_pkg::MESI_I)
			begin
				empty = 1'b1;
				empty_way = w[cache_pkg::WAY_WIDTH-1:0];
			end
			// least recently used
			if (rd_lru[w] == '0)
				lru_way = w[cache_pkg::WAY_WIDTH-1:0];
		end
	end

	// fill an empty way before evicting
	assign victim_way = empty ? empty_way : lru_way;

	////////////////////////////////////////////////////////////
	// lru touch
	////////////////////////////////////////////////////////////

	assign touched_lru = rd_lru[touch_way];

	// ways above the touched one slide down by one
	always_comb
	begin
		for (int w = 0; w < cache_pkg::WAYS; w++)
		begin
			if (w == int'(touch_way))
				new_lru[w] = '1;
			else if (rd_lru[w] > touched_lru)
				new_lru[w] = rd_lru[w] - 1'b1;
			else
				new_lru[w] = rd_lru[w];
		end
	end

endmodule

/* cache_set_store.sv */
`timescale 1ns/1ps

module cache_set_store #(
	parameter int INDEX_WIDTH = 14,
	localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH,
	localparam int SETS = 1 << INDEX_WIDTH
) (
	input logic clk,
	input logic rst,
	input logic rd_en,
	input logic [INDEX_WIDTH-1:0] rd_index,
	output logic [cache_pkg::WAYS-1:0][TAG_WIDTH-1:0] rd_tags,
	output cache_pkg::mesi_e [cache_pkg::WAYS-1:0] rd_states,
	output logic [cache_pkg::WAYS-1:0][cache_pkg::LRU_WIDTH-1:0] rd_lru,
	input logic wr_en,
	input logic [INDEX_WIDTH-1:0] wr_index,
	input logic [cache_pkg::WAYS-1:0][TAG_WIDTH-1:0] wr_tags,
	input cache_pkg::mesi_e [cache_pkg::WAYS-1:0] wr_states,
	input logic [cache_pkg::WAYS-1:0][cache_pkg::LRU_WIDTH-1:0] wr_lru
);

	// one entry per set, all ways side by side
	logic [cache_pkg::WAYS-1:0][TAG_WIDTH-1:0] tag_mem [SETS];
	cache_pkg::mesi_e [cache_pkg::WAYS-1:0] state_mem [SETS];
	logic [cache_pkg::WAYS-1:0][cache_pkg::LRU_WIDTH-1:0] lru_mem [SETS];

	// set being cleared while rst is held
	logic [INDEX_WIDTH-1:0] clr_index = '0;
	cache_pkg::mesi_e [cache_pkg::WAYS-1:0] init_states;
	logic [cache_pkg::WAYS-1:0][cache_pkg::LRU_WIDTH-1:0] init_lru;

	// empty set, counters start at the way number
	always_comb
	begin
		for (int w = 0; w < cache_pkg::WAYS; w++)
		begin
			init_states[w] = cache_pkg::MESI_I;
			init_lru[w] = w[cache_pkg::LRU_WIDTH-1:0];
		end
	end

	// state and lru, one set per reset cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_mem[clr_index] <= init_states;
			lru_mem[clr_index] <= init_lru;
			clr_index <= clr_index + 1'b1;
		end
		else
		begin
			clr_index <= '0;
			if (wr_en)
			begin
				state_mem[wr_index] <= wr_states;
				lru_mem[wr_index] <= wr_lru;
			end
		end
	end

	// tags only matter behind a valid state
	always_ff @(posedge clk)
	begin
		if (wr_en)
			tag_mem[wr_index] <= wr_tags;
	end

	// registered read, data one cycle after rd_en
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			rd_tags <= tag_mem[rd_index];
			rd_states <= state_mem[rd_index];
			rd_lru <= lru_mem[rd_index];
		end
	end

endmodule

/* cache_pkg.sv */
package cache_pkg;

	////////////////////////////////////////////////////////////
	// geometry
	////////////////////////////////////////////////////////////

	// byte address from the trace
	localparam int ADDR_WIDTH = 32;
	// 64-byte lines
	localparam int OFFSET_WIDTH = 6;
	// 8-way set associative
	localparam int WAYS = 8;
	localparam int WAY_WIDTH = $clog2(WAYS);
	// one counter per way, 7 is most recent
	localparam int LRU_WIDTH = 3;

	////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////

	// trace opcodes, 5 (stall) is not decoded
	typedef enum logic [2:0]
	{
		CMD_READ = 3'd0,
		CMD_WRITE = 3'd1,
		CMD_IFETCH = 3'd2,
		CMD_SNOOP_INV = 3'd3,
		CMD_SNOOP_RD = 3'd4,
		CMD_SNOOP_RWIM = 3'd6
	} cmd_e;

	typedef enum logic [1:0]
	{
		MESI_M = 2'd0,
		MESI_E = 2'd1,
		MESI_S = 2'd2,
		MESI_I = 2'd3
	} mesi_e;

	typedef enum logic [1:0]
	{
		SNOOP_HIT = 2'd0,
		SNOOP_HITM = 2'd1,
		SNOOP_MISS = 2'd2
	} snoop_e;

	// write-back of a victim goes out on the evict port
	typedef enum logic [1:0]
	{
		BUS_READ = 2'd0,
		BUS_WRITE = 2'd1,
		BUS_RWIM = 2'd2,
		BUS_INVALIDATE = 2'd3
	} bus_op_e;

endpackage
